//--- design/blit_addr_gen.sv
/* Blitter address generator */

`timescale 1ns/1ps
`default_nettype none

`include "blit_defs.svh"

module blit_addr_gen
(
	input  wire                                          sys_clk,
	input  wire                                          rst_n,
	input  wire                                          issue,
	input  wire                                          zaddr,
	input  wire                                          last,
	input  wire blit_pkg::chan_e                         chan,
	input  wire blit_pkg::ptr_cfg_t [`BLIT_NUM_PTRS-1:0] ptr_cfg,
	input  wire blit_pkg::ptr_pos_t [`BLIT_NUM_PTRS-1:0] ptr_pos,
	output logic                                         req_valid,
	output blit_pkg::mem_req_t                           req
);
	import blit_pkg::*;

	// Pixel address is one wider than the y term
	localparam int PA_W  = `BLIT_ADDR_W + 1;
	// Bit address, phrase index sits at [PIX_W-1:6]
	localparam int PIX_W = `BLIT_BASE_W + 6;

	ptr_cfg_t                sel_cfg;
	ptr_pos_t                sel_pos;
	logic [`BLIT_ADDR_W-1:0] y_ext;
	logic [`BLIT_ADDR_W-1:0] y_mul;
	logic [`BLIT_ADDR_W-1:0] ya;
	logic [PA_W-1:0]         pa;
	logic [2:0]              eff_size;
	logic [PIX_W-1:0]        pixbit;
	logic [`BLIT_BASE_W-1:0] phr_idx;
	logic [`BLIT_BASE_W-1:0] stride;
	logic [`BLIT_BASE_W-1:0] z_add;
	logic [`BLIT_BASE_W-1:0] phr_addr;
	logic [`BLIT_ADDR_W-1:0] byte_addr;

	// Window select by channel
	assign sel_cfg = ptr_cfg[chan];
	assign sel_pos = ptr_pos[chan];

	always_comb
	begin
		y_ext = `BLIT_ADDR_W'(sel_pos.y);

		// y * (4 + 2*w1 + w0), built from shifted adds
		y_mul = y_ext << 2;
		if (sel_cfg.width[1])
			y_mul = y_mul + (y_ext << 1);
		if (sel_cfg.width[0])
			y_mul = y_mul + y_ext;

		// Exponent part scales by 2^w/4
		// Codes with width[5:4] = 3 give no y term
		if (&sel_cfg.width[5:4])
			ya = '0;
		else
			ya = (y_mul << sel_cfg.width[5:2]) >> 2;

		pa = {1'b0, ya} + PA_W'(sel_pos.x);

		// Sizes 6 and 7 alias 4 and 5
		if (&sel_cfg.pix_size[2:1])
			eff_size = sel_cfg.pix_size & 3'b101;
		else
			eff_size = sel_cfg.pix_size;

		pixbit  = PIX_W'(pa) << eff_size;
		phr_idx = pixbit[PIX_W-1:6];

		// Pitch spreads phrases for interleaved planes
		case (sel_cfg.pitch)
			2'd0: stride = phr_idx;
			2'd1: stride = phr_idx << 1;
			2'd2: stride = phr_idx << 2;
			default: stride = {phr_idx[`BLIT_BASE_W-2:0], 1'b0};
		endcase

		z_add = zaddr ? `BLIT_BASE_W'(sel_cfg.z_offset) : '0;

		// Phrase address wraps at the base width
		phr_addr  = sel_cfg.base + stride + z_add;
		byte_addr = {phr_addr, pixbit[5:3]};
	end

	// One request per cycle, out one cycle after issue
	always_ff @(posedge sys_clk or negedge rst_n)
	begin
		if (!rst_n)
			req_valid <= 1'b0;
		else
			req_valid <= issue;
	end

	always_ff @(posedge sys_clk)
	begin
		if (issue)
		begin
			req.addr <= byte_addr;
			req.chan <= chan;
			req.z    <= zaddr;
			req.last <= last;
		end
	end

endmodule

`default_nettype wire

//--- design/blit_addr_top.sv
/* Blitter address path top */

`timescale 1ns/1ps
`default_nettype none

`include "blit_defs.svh"

module blit_addr_top
(
	input  wire                       sys_clk,
	input  wire                       rst_n,
	input  wire                       cfg_valid,
	input  wire blit_pkg::cfg_reg_e   cfg_reg,
	input  wire [31:0]                cfg_data,
	input  wire                       credit_return,
	output logic                      req_valid,
	output blit_pkg::mem_req_t        req,
	output logic                      busy,
	output logic                      done
);
	import blit_pkg::*;

	ptr_cfg_t [`BLIT_NUM_PTRS-1:0] ptr_cfg;
	ptr_pos_t [`BLIT_NUM_PTRS-1:0] ptr_pos;
	logic                          load;
	logic                          start;
	blit_op_e                      op;
	logic [`BLIT_CNT_W-1:0]        line_pixels;
	logic [`BLIT_CNT_W-1:0]        lines;
	logic                          issue;
	logic                          zaddr;
	logic                          last;
	logic                          line_end;
	chan_e                         chan;
	logic [`BLIT_NUM_PTRS-1:0]     step;

	blit_cmd_decoder blit_cmd_decoder_inst
	(
		.sys_clk     (sys_clk),
		.rst_n       (rst_n),
		.cfg_valid   (cfg_valid),
		.cfg_reg     (cfg_reg),
		.cfg_data    (cfg_data),
		.busy        (busy),
		.ptr_cfg     (ptr_cfg),
		.load        (load),
		.start       (start),
		.op          (op),
		.line_pixels (line_pixels),
		.lines       (lines)
	);

	// One unit per window, index matches chan_e
	for (genvar i = 0; i < `BLIT_NUM_PTRS; i++)
	begin : g_ptr
		blit_pointer_unit blit_pointer_unit_inst
		(
			.sys_clk  (sys_clk),
			.rst_n    (rst_n),
			.cfg      (ptr_cfg[i]),
			.load     (load),
			.step     (step[i]),
			.line_end (line_end),
			.pos      (ptr_pos[i])
		);
	end

	blit_sequencer blit_sequencer_inst
	(
		.sys_clk       (sys_clk),
		.rst_n         (rst_n),
		.start         (start),
		.op            (op),
		.line_pixels   (line_pixels),
		.lines         (lines),
		.credit_return (credit_return),
		.issue         (issue),
		.zaddr         (zaddr),
		.last          (last),
		.line_end      (line_end),
		.chan          (chan),
		.step          (step),
		.busy          (busy),
		.done          (done)
	);

	blit_addr_gen blit_addr_gen_inst
	(
		.sys_clk   (sys_clk),
		.rst_n     (rst_n),
		.issue     (issue),
		.zaddr     (zaddr),
		.last      (last),
		.chan      (chan),
		.ptr_cfg   (ptr_cfg),
		.ptr_pos   (ptr_pos),
		.req_valid (req_valid),
		.req       (req)
	);

endmodule

`default_nettype wire

//--- design/blit_cmd_decoder.sv
/* Blitter command decoder */

`timescale 1ns/1ps
`default_nettype none

`include "blit_defs.svh"

module blit_cmd_decoder
(
	input  wire                                          sys_clk,
	input  wire                                          rst_n,
	input  wire                                          cfg_valid,
	input  wire blit_pkg::cfg_reg_e                      cfg_reg,
	input  wire [31:0]                                   cfg_data,
	input  wire                                          busy,
	output blit_pkg::ptr_cfg_t [`BLIT_NUM_PTRS-1:0]      ptr_cfg,
	output logic                                         load,
	output logic                                         start,
	output blit_pkg::blit_op_e                           op,
	output logic [`BLIT_CNT_W-1:0]                       line_pixels,
	output logic [`BLIT_CNT_W-1:0]                       lines
);
	import blit_pkg::*;

	logic accept;
	logic cmd_write;

	// Writes only land while the engine is idle
	// The cycle holding start counts as busy too
	assign accept = cfg_valid && !busy && !start;
	assign cmd_write = accept && (cfg_reg == BLT_CMD);

	// Register file
	always_ff @(posedge sys_clk)
	begin
		if (accept)
		begin
			case (cfg_reg)
				A1_BASE: ptr_cfg[CH_A1].base <= cfg_data[`BLIT_BASE_W-1:0];
				A2_BASE: ptr_cfg[CH_A2].base <= cfg_data[`BLIT_BASE_W-1:0];
				// x in the low half, y in the high half
				A1_POS:
				begin
					ptr_cfg[CH_A1].x_start <= cfg_data[15:0];
					ptr_cfg[CH_A1].y_start <= cfg_data[31:16];
				end
				A2_POS:
				begin
					ptr_cfg[CH_A2].x_start <= cfg_data[15:0];
					ptr_cfg[CH_A2].y_start <= cfg_data[31:16];
				end
				// Width code, pixel size, pitch, z-offset
				A1_FMT:
				begin
					ptr_cfg[CH_A1].width    <= cfg_data[5:0];
					ptr_cfg[CH_A1].pix_size <= cfg_data[8:6];
					ptr_cfg[CH_A1].pitch    <= cfg_data[10:9];
					ptr_cfg[CH_A1].z_offset <= cfg_data[12:11];
				end
				A2_FMT:
				begin
					ptr_cfg[CH_A2].width    <= cfg_data[5:0];
					ptr_cfg[CH_A2].pix_size <= cfg_data[8:6];
					ptr_cfg[CH_A2].pitch    <= cfg_data[10:9];
					ptr_cfg[CH_A2].z_offset <= cfg_data[12:11];
				end
				BLT_SIZE:
				begin
					line_pixels <= cfg_data[15:0];
					lines       <= cfg_data[31:16];
				end
				default: op <= blit_op_e'(cfg_data[1:0]);
			endcase
		end
	end

	// Load and start pulse together, one cycle after the command
	always_ff @(posedge sys_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			load  <= 1'b0;
			start <= 1'b0;
		end
		else
		begin
			load  <= cmd_write;
			start <= cmd_write;
		end
	end

	// Sequencer must be idle when a blit is started
	a_start_idle: assert property (@(posedge sys_clk) disable iff (!rst_n)
		start |-> !busy);

	// and it must pick the start up on the same edge
	a_start_busy: assert property (@(posedge sys_clk) disable iff (!rst_n)
		start |=> busy);

endmodule

`default_nettype wire

//--- design/blit_defs.svh
/* Blitter address path parameters */

`ifndef BLIT_DEFS_SVH
`define BLIT_DEFS_SVH

// Pointer windows, A1 source and A2 destination
`define BLIT_NUM_PTRS 2

// Requests allowed in flight before a credit must come back
`define BLIT_CREDITS 4

// Byte address out of the address generator
`define BLIT_ADDR_W 24

// Phrase base address, byte address less the 3 lane bits
`define BLIT_BASE_W 21

// Pixel and line counters, also the x/y position width
`define BLIT_CNT_W 16

`endif

//--- design/blit_pkg.sv
/* Blitter shared types */

`default_nettype none

`include "blit_defs.svh"

package blit_pkg;

	// Blit opcodes, selects the requests per pixel
	typedef enum logic [1:0]
	{
		BLT_FILL,
		BLT_COPY,
		BLT_ZCOPY
	} blit_op_e;

	// Configuration register index
	typedef enum logic [2:0]
	{
		A1_BASE,
		A1_POS,
		A1_FMT,
		A2_BASE,
		A2_POS,
		A2_FMT,
		BLT_SIZE,
		BLT_CMD
	} cfg_reg_e;

	// One pointer window as programmed
	typedef struct packed
	{
		logic [`BLIT_BASE_W-1:0] base;
		logic [`BLIT_CNT_W-1:0]  x_start;
		logic [`BLIT_CNT_W-1:0]  y_start;
		logic [5:0]              width;
		logic [2:0]              pix_size;
		logic [1:0]              pitch;
		logic [1:0]              z_offset;
	} ptr_cfg_t;

	// Current pixel position of a window
	typedef struct packed
	{
		logic [`BLIT_CNT_W-1:0] x;
		logic [`BLIT_CNT_W-1:0] y;
	} ptr_pos_t;

	// Channel of a request, doubles as pointer index
	typedef enum logic
	{
		CH_A1,
		CH_A2
	} chan_e;

	// Outgoing memory request
	typedef struct packed
	{
		logic [`BLIT_ADDR_W-1:0] addr;
		chan_e                   chan;
		logic                    z;
		logic                    last;
	} mem_req_t;

	typedef enum logic [1:0]
	{
		IDLE,
		ISSUE,
		DRAIN
	} seq_state_e;

endpackage

`default_nettype wire

//--- design/blit_pointer_unit.sv
/* Blitter pointer unit */

`timescale 1ns/1ps
`default_nettype none

module blit_pointer_unit
(
	input  wire                      sys_clk,
	input  wire                      rst_n,
	input  wire blit_pkg::ptr_cfg_t  cfg,
	input  wire                      load,
	input  wire                      step,
	input  wire                      line_end,
	output blit_pkg::ptr_pos_t       pos
);

	// Position walks the rectangle in raster order
	// x runs +1 per pixel, y +1 per line
	always_ff @(posedge sys_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pos <= '0;
		end
		else if (load)
		begin
			// Start of blit, go to the window origin
			pos.x <= cfg.x_start;
			pos.y <= cfg.y_start;
		end
		else if (step)
		begin
			if (line_end)
			begin
				// Back to the left edge, next line down
				pos.x <= cfg.x_start;
				pos.y <= pos.y + 1'b1;
			end
			else
			begin
				pos.x <= pos.x + 1'b1;
			end
		end
	end

	// Load comes from the decoder, step from the sequencer
	// A step during load would be lost
	a_no_step_on_load: assert property (@(posedge sys_clk) disable iff (!rst_n)
		!(load && step));

endmodule

`default_nettype wire

//--- design/blit_sequencer.sv
/* Blitter request sequencer */

`timescale 1ns/1ps
`default_nettype none

`include "blit_defs.svh"

module blit_sequencer
(
	input  wire                       sys_clk,
	input  wire                       rst_n,
	input  wire                       start,
	input  wire blit_pkg::blit_op_e   op,
	input  wire [`BLIT_CNT_W-1:0]     line_pixels,
	input  wire [`BLIT_CNT_W-1:0]     lines,
	input  wire                       credit_return,
	output logic                      issue,
	output logic                      zaddr,
	output logic                      last,
	output logic                      line_end,
	output blit_pkg::chan_e           chan,
	output logic [`BLIT_NUM_PTRS-1:0] step,
	output logic                      busy,
	output logic                      done
);
	import blit_pkg::*;

	localparam int CRED_W = $clog2(`BLIT_CREDITS + 1);

	seq_state_e             state;
	logic [`BLIT_CNT_W-1:0] pix_cnt;
	logic [`BLIT_CNT_W-1:0] line_cnt;
	logic [1:0]             phase;
	logic [1:0]             final_phase;
	logic [CRED_W-1:0]      credits;
	logic                   pixel_done;
	logic                   last_line;

	always_comb
	begin
		// Requests per pixel minus one
		case (op)
			BLT_FILL: final_phase = 2'd0;
			BLT_COPY: final_phase = 2'd1;
			default:  final_phase = 2'd2;
		endcase

		// Phase 0 reads A1 unless filling
		// Later phases write A2
		chan  = (op != BLT_FILL && phase == 2'd0) ? CH_A1 : CH_A2;
		zaddr = (op == BLT_ZCOPY) && (phase == 2'd2);

		pixel_done = (phase == final_phase);
		line_end   = (pix_cnt == line_pixels - 1'b1);
		last_line  = (line_cnt == lines - 1'b1);
		last       = pixel_done && line_end && last_line;

		// Credits gate every request
		issue = (state == ISSUE) && (credits != '0);

		// A pointer moves after its final request of the pixel
		step        = '0;
		step[CH_A1] = issue && (chan == CH_A1);
		step[CH_A2] = issue && pixel_done;
	end

	assign busy = (state != IDLE);

	// Credit counter
	// A return may coincide with an issue
	always_ff @(posedge sys_clk or negedge rst_n)
	begin
		if (!rst_n)
			credits <= CRED_W'(`BLIT_CREDITS);
		else
			credits <= credits - CRED_W'(issue) + CRED_W'(credit_return);
	end

	always_ff @(posedge sys_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state    <= IDLE;
			pix_cnt  <= '0;
			line_cnt <= '0;
			phase    <= '0;
			done     <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			case (state)
				IDLE:
				begin
					if (start)
					begin
						state    <= ISSUE;
						pix_cnt  <= '0;
						line_cnt <= '0;
						phase    <= '0;
					end
				end
				ISSUE:
				begin
					// Without a credit everything holds
					if (issue)
					begin
						if (!pixel_done)
						begin
							phase <= phase + 1'b1;
						end
						else
						begin
							phase <= '0;
							if (!line_end)
								pix_cnt <= pix_cnt + 1'b1;
							else
							begin
								pix_cnt <= '0;
								if (last_line)
									state <= DRAIN;
								else
									line_cnt <= line_cnt + 1'b1;
							end
						end
					end
				end
				DRAIN:
				begin
					// Finished once every credit is home
					if (credits == CRED_W'(`BLIT_CREDITS))
					begin
						state <= IDLE;
						done  <= 1'b1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Memory side never returns more than it was given
	a_credit_max: assert property (@(posedge sys_clk) disable iff (!rst_n)
		credits <= CRED_W'(`BLIT_CREDITS));

	// No request leaves an empty counter, only a return refills it
	a_no_issue_dry: assert property (@(posedge sys_clk) disable iff (!rst_n)
		(credits == '0 && !credit_return) |=> (credits == '0));

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the blitter address path testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module blit_addr_tb \
	-f sources.f \
	-o blit_addr_sim

./obj_dir/blit_addr_sim | tee sim.log

if grep -q "Simulation passed" sim.log
then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi

//--- sources.f
+incdir+design
design/blit_pkg.sv
design/blit_cmd_decoder.sv
design/blit_pointer_unit.sv
design/blit_sequencer.sv
design/blit_addr_gen.sv
design/blit_addr_top.sv
tests/blit_addr_tb.sv

//--- tests/blit_addr_tb.sv
/* Blitter address path testbench */

`timescale 1ns/1ps
`default_nettype none

`include "blit_defs.svh"

module blit_addr_tb;
	import blit_pkg::*;

	logic        sys_clk;
	logic        rst_n;
	logic        cfg_valid;
	cfg_reg_e    cfg_reg;
	logic [31:0] cfg_data;
	logic        credit_return;
	logic        req_valid;
	mem_req_t    req;
	logic        busy;
	logic        done;

	// Window settings as last accepted by the DUT
	ptr_cfg_t    win [`BLIT_NUM_PTRS];
	mem_req_t    got_q [$];
	mem_req_t    exp_q [$];
	// Cycle at which each outstanding request gets its credit back
	int          due_q [$];
	int          cycle;
	int          ret_delay;
	bit          paused;
	int          errors;
	integer      seed;

	blit_addr_top blit_addr_top_inst
	(
		.sys_clk       (sys_clk),
		.rst_n         (rst_n),
		.cfg_valid     (cfg_valid),
		.cfg_reg       (cfg_reg),
		.cfg_data      (cfg_data),
		.credit_return (credit_return),
		.req_valid     (req_valid),
		.req           (req),
		.busy          (busy),
		.done          (done)
	);

	initial
	begin
		sys_clk = 1'b0;
		forever #50 sys_clk = ~sys_clk;
	end

	// Request monitor
	always @(negedge sys_clk)
	begin
		if (req_valid)
			got_q.push_back(req);
	end

	// Memory side returns one credit per request after ret_delay cycles
	always @(negedge sys_clk)
	begin
		cycle++;
		if (req_valid)
			due_q.push_back(cycle + ret_delay);
		if (!paused && due_q.size() != 0 && due_q[0] <= cycle)
		begin
			credit_return = 1'b1;
			void'(due_q.pop_front());
		end
		else
			credit_return = 1'b0;
	end

	// Byte address of pixel (x, y) in window c
	function automatic logic [23:0] model_addr(ptr_cfg_t c, logic [15:0] x, logic [15:0] y,
		bit z);
		logic [23:0] ya;
		logic [24:0] pa;
		logic [2:0]  eff;
		logic [31:0] pixbit;
		logic [31:0] index;
		logic [31:0] stride;
		logic [20:0] phr;
		// Line width is mantissa (4..7)/4 times 2^exponent
		ya = 24'(y) * 24'(4 + 2 * c.width[1] + c.width[0]);
		ya = ya << c.width[5:2];
		ya = ya >> 2;
		if (c.width[5:4] == 2'b11)
			ya = '0;
		pa = 25'(ya) + 25'(x);
		eff = (c.pix_size >= 3'd6) ? c.pix_size - 3'd2 : c.pix_size;
		pixbit = 32'(pa) << eff;
		index = pixbit >> 6;
		case (c.pitch)
			2'd0: stride = index;
			2'd1: stride = index << 1;
			2'd2: stride = index << 2;
			default: stride = (index % (1 << 20)) << 1;
		endcase
		phr = 21'(c.base + stride + (z ? c.z_offset : 0));
		return {phr, pixbit[5:3]};
	endfunction

	// Request for pixel i of line j on one channel
	function automatic mem_req_t expected_req(chan_e ch, int i, int j, bit z);
		mem_req_t r;
		r.addr = model_addr(win[ch], 16'(win[ch].x_start + i), 16'(win[ch].y_start + j), z);
		r.chan = ch;
		r.z    = z;
		r.last = 1'b0;
		return r;
	endfunction

	task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
		if (got !== exp)
		begin
			errors++;
			$display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic report_failure(string what);
		errors++;
		$display("Failure: %s", what);
	endtask

	task automatic cfg_write(cfg_reg_e r, logic [31:0] d);
		@(negedge sys_clk);
		cfg_valid = 1'b1;
		cfg_reg   = r;
		cfg_data  = d;
		@(negedge sys_clk);
		cfg_valid = 1'b0;
	endtask

	task automatic program_window(chan_e ch, ptr_cfg_t c);
		win[ch] = c;
		cfg_write((ch == CH_A1) ? A1_BASE : A2_BASE, 32'(c.base));
		cfg_write((ch == CH_A1) ? A1_POS : A2_POS, {c.y_start, c.x_start});
		cfg_write((ch == CH_A1) ? A1_FMT : A2_FMT,
			{19'd0, c.z_offset, c.pitch, c.pix_size, c.width});
	endtask

	task automatic wait_busy();
		int t;
		t = 0;
		while (!busy && t < 100)
		begin
			@(negedge sys_clk);
			t++;
		end
		if (!busy)
			report_failure("busy never rose after the blit command");
	endtask

	task automatic wait_done();
		int t;
		t = 0;
		while (!done && t < 2000)
		begin
			@(negedge sys_clk);
			t++;
		end
		if (!done)
			report_failure("timed out waiting for done");
		else
		begin
			check_value("busy", busy, 1'b0);
			@(negedge sys_clk);
			check_value("done", done, 1'b0);
		end
	endtask

	// Raster walk with A1 read then A2 write then A2 z write per pixel
	task automatic start_blit(blit_op_e op, int npix, int nlines);
		exp_q.delete();
		got_q.delete();
		for (int j = 0; j < nlines; j++)
			for (int i = 0; i < npix; i++)
			begin
				if (op != BLT_FILL)
					exp_q.push_back(expected_req(CH_A1, i, j, 1'b0));
				exp_q.push_back(expected_req(CH_A2, i, j, 1'b0));
				if (op == BLT_ZCOPY)
					exp_q.push_back(expected_req(CH_A2, i, j, 1'b1));
			end
		exp_q[$].last = 1'b1;
		cfg_write(BLT_SIZE, {16'(nlines), 16'(npix)});
		cfg_write(BLT_CMD, 32'(op));
	endtask

	task automatic finish_blit();
		int n;
		wait_done();
		check_value("req_count", got_q.size(), exp_q.size());
		n = (got_q.size() < exp_q.size()) ? got_q.size() : exp_q.size();
		for (int k = 0; k < n; k++)
		begin
			check_value($sformatf("req[%0d].addr", k), got_q[k].addr, exp_q[k].addr);
			check_value($sformatf("req[%0d].chan", k), got_q[k].chan, exp_q[k].chan);
			check_value($sformatf("req[%0d].z", k), got_q[k].z, exp_q[k].z);
			check_value($sformatf("req[%0d].last", k), got_q[k].last, exp_q[k].last);
		end
	endtask

	task automatic run_blit(blit_op_e op, int npix, int nlines);
		start_blit(op, npix, nlines);
		finish_blit();
	endtask

	// Idle outputs after reset and writes dropped during a blit
	task automatic reset_and_busy_write();
		check_value("req_valid", req_valid, 1'b0);
		check_value("busy", busy, 1'b0);
		check_value("done", done, 1'b0);
		program_window(CH_A1, '{21'h00_1000, 16'd2, 16'd1, 6'd12, 3'd4, 2'd0, 2'd1});
		program_window(CH_A2, '{21'h08_0000, 16'd0, 16'd4, 6'd17, 3'd3, 2'd1, 2'd2});
		start_blit(BLT_COPY, 2, 2);
		wait_busy();
		cfg_write(A2_FMT, 32'h0000_1fff);
		cfg_write(A2_BASE, 32'h001f_ffff);
		cfg_write(BLT_CMD, 32'(BLT_ZCOPY));
		finish_blit();
		run_blit(BLT_COPY, 2, 2);
	endtask

	// Covers x reload and y step with pitch 0 to 2
	task automatic copy_walk();
		program_window(CH_A1, '{21'h01_2340, 16'd5, 16'd3, 6'd13, 3'd3, 2'd0, 2'd1});
		program_window(CH_A2, '{21'h10_0000, 16'd10, 16'd7, 6'd22, 3'd5, 2'd2, 2'd2});
		run_blit(BLT_COPY, 3, 2);
		program_window(CH_A2, '{21'h0f_fff0, 16'd1, 16'd9, 6'd30, 3'd2, 2'd1, 2'd3});
		run_blit(BLT_COPY, 3, 2);
	endtask

	task automatic zcopy_and_fill();
		program_window(CH_A2, '{21'h04_0200, 16'd3, 16'd2, 6'd14, 3'd6, 2'd1, 2'd3});
		run_blit(BLT_ZCOPY, 2, 2);
		run_blit(BLT_FILL, 4, 1);
	endtask

	// Pitch 3 and the width codes that drop the y term
	task automatic pitch3_and_width();
		program_window(CH_A1, '{21'h1f_ff00, 16'd7, 16'hfff0, 6'b110101, 3'd7, 2'd3, 2'd0});
		program_window(CH_A2, '{21'h02_0000, 16'd4, 16'd900, 6'b101011, 3'd4, 2'd3, 2'd1});
		run_blit(BLT_COPY, 2, 3);
		program_window(CH_A2, '{21'h02_0000, 16'd4, 16'd900, 6'b111110, 3'd1, 2'd3, 2'd1});
		run_blit(BLT_ZCOPY, 2, 2);
	endtask

	task automatic backpressure_stall();
		int t;
		paused = 1'b1;
		start_blit(BLT_COPY, 3, 2);
		t = 0;
		while (got_q.size() < `BLIT_CREDITS && t < 100)
		begin
			@(negedge sys_clk);
			t++;
		end
		// Nothing more may leave while the returns are held
		repeat (10) @(negedge sys_clk);
		check_value("req_count_stalled", got_q.size(), `BLIT_CREDITS);
		check_value("busy", busy, 1'b1);
		paused = 1'b0;
		finish_blit();
	endtask

	task automatic random_blits();
		ptr_cfg_t c;
		blit_op_e op;
		for (int n = 0; n < 5; n++)
		begin
			for (int ch = 0; ch < `BLIT_NUM_PTRS; ch++)
			begin
				c.base     = 21'($random(seed));
				c.x_start  = 16'($random(seed));
				c.y_start  = 16'($random(seed));
				c.width    = 6'($random(seed));
				c.pix_size = 3'($random(seed));
				c.pitch    = 2'($random(seed));
				c.z_offset = 2'($random(seed));
				program_window(chan_e'(ch), c);
			end
			op = ($random(seed) & 1) ? BLT_COPY : BLT_FILL;
			ret_delay = $random(seed) & 7;
			run_blit(op, 1 + ($random(seed) & 3), 1 + ($random(seed) & 3));
		end
	endtask

	initial
	begin
		seed          = 6;
		errors        = 0;
		paused        = 1'b0;
		ret_delay     = 3;
		rst_n         = 1'b0;
		cfg_valid     = 1'b0;
		cfg_reg       = A1_BASE;
		cfg_data      = '0;
		credit_return = 1'b0;
		repeat (4) @(negedge sys_clk);
		rst_n = 1'b1;

		reset_and_busy_write();
		copy_walk();
		zcopy_and_fill();
		pitch3_and_width();
		backpressure_stall();
		random_blits();

		$display("Checks finished with %0d errors", errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire
